// ==== project.f ====
verilog/core_pkg.sv
verilog/if_stage.sv
verilog/pipe_reg.sv
verilog/id_stage.sv
verilog/reg_file.sv
verilog/ex_stage.sv
verilog/core_top.sv
tests/core_tb.sv

// ==== tests/core_tb.sv ====
// rv64i core testbench
`timescale 1ns/100ps
module core_tb;
    import core_pkg::*;

    localparam logic [ilen-1:0] nop_inst = 32'h0000_0013;   // addi x0, x0, 0
    localparam int              prog_max = 64;

    logic                  clk;
    logic                  reset_i;
    logic [xlen-1:0]       pc_o;
    logic [ilen-1:0]       inst_i;
    logic                  retire_valid_o;
    logic [xlen-1:0]       retire_pc_o;
    logic [reg_addr_w-1:0] retire_rd_o;
    logic [xlen-1:0]       retire_data_o;
    logic                  retire_wen_o;
    logic                  halt_o;
    logic                  illegal_o;

    logic [ilen-1:0] prog [prog_max];
    logic [xlen-1:0] mregs [reg_count];                   // model register state
    int              prog_len = 0;
    int              stop_idx = 0;                        // halting inst
    int              ret_idx  = 0;
    int              errors   = 0;
    int              n_pass   = 0;
    int              n_fail   = 0;
    int              cycles   = 0;
    int              limit    = 40;                       // grows with each program

    core_top dut_i (.clk(clk), .reset_i(reset_i), .pc_o(pc_o), .inst_i(inst_i),
        .retire_valid_o(retire_valid_o), .retire_pc_o(retire_pc_o),
        .retire_rd_o(retire_rd_o), .retire_data_o(retire_data_o),
        .retire_wen_o(retire_wen_o), .halt_o(halt_o), .illegal_o(illegal_o));

    always #5 clk = ~clk;

    always_comb begin
        if ((pc_o >> 2) < prog_len) begin
            inst_i = prog[pc_o[7:2]];
        end else begin
            inst_i = nop_inst;                            // outside the program
        end
    end

    function automatic logic [ilen-1:0] enc_r(input logic [6:0] f7, input int rs2, rs1,
                                             input logic [2:0] f3, input int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], op_reg};
    endfunction

    function automatic logic [ilen-1:0] enc_i(input logic [11:0] imm, input int rs1,
                                             input logic [2:0] f3, input int rd);
        return {imm, rs1[4:0], f3, rd[4:0], op_imm};
    endfunction

    function automatic logic [ilen-1:0] enc_u(input logic [6:0] op, input logic [19:0] imm,
                                             input int rd);
        return {imm, rd[4:0], op};
    endfunction

    function automatic int rand_reg();
        return 1 + $urandom % 31;
    endfunction

    // register or immediate form with a random function
    function automatic logic [ilen-1:0] rand_op(input int rd, rs1, rs2);
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        f3  = 3'($urandom);
        alt = 1'($urandom) && (f3 == 3'b000 || f3 == 3'b101);
        imm = 12'($urandom);
        if (1'($urandom)) begin
            return enc_r(alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd);
        end
        if (f3 == 3'b001) begin
            imm = {6'b0, imm[5:0]};                       // 6-bit shamt
        end else if (f3 == 3'b101) begin
            imm = {1'b0, imm[10], 4'b0, imm[5:0]};        // bit 10 picks srai
        end
        return enc_i(imm, rs1, f3, rd);
    endfunction

    function automatic logic [xlen-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                               input logic [xlen-1:0] a, b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[5:0];
            3'b010:  return {63'b0, $signed(a) < $signed(b)};
            3'b011:  return {63'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? $unsigned($signed(a) >>> b[5:0]) : a >> b[5:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // architectural effect of one instruction on the model registers
    function automatic void model_step(input logic [ilen-1:0] inst, input logic [xlen-1:0] pc,
                                       output logic [4:0] rd, output logic [xlen-1:0] data,
                                       output logic wen);
        logic [xlen-1:0] a;
        logic [xlen-1:0] imm_i;
        logic [xlen-1:0] imm_u;
        a     = mregs[inst[19:15]];
        imm_i = {{52{inst[31]}}, inst[31:20]};
        imm_u = {{32{inst[31]}}, inst[31:12], 12'h000};
        rd    = inst[11:7];
        wen   = 1'b1;
        data  = '0;
        case (inst[6:0])
            op_reg:   data = alu_ref(inst[14:12], inst[30], a, mregs[inst[24:20]]);
            op_imm:   data = alu_ref(inst[14:12], inst[14:12] == 3'b101 && inst[30], a, imm_i);
            op_lui:   data = imm_u;
            op_auipc: data = pc + imm_u;
            default:  wen = 1'b0;                         // ebreak or unknown halts
        endcase
        if (wen && rd != 0) begin
            mregs[rd] = data;
        end
    endfunction

    task automatic check_field(input string name, input logic [xlen-1:0] exp, got);
        if (got !== exp) begin
            $display("mismatch %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    always @(posedge clk) begin : retire_check
        logic [4:0]      exp_rd;
        logic [xlen-1:0] exp_data;
        logic            exp_wen;
        if (!reset_i && retire_valid_o) begin
            if (ret_idx > stop_idx) begin
                $display("instruction at pc %h retired after the halt", retire_pc_o);
                errors++;
            end else begin
                model_step(prog[ret_idx], 64'(ret_idx * 4), exp_rd, exp_data, exp_wen);
                check_field("retire_pc_o", 64'(ret_idx * 4), retire_pc_o);
                if (ret_idx + 2 <= stop_idx) begin
                    check_field("pc_o", 64'((ret_idx + 3) * 4), pc_o);  // fetch three ahead
                end
                check_field("halt_o", 64'(ret_idx == stop_idx), 64'(halt_o));
                check_field("retire_rd_o", 64'(exp_rd), 64'(retire_rd_o));
                check_field("retire_wen_o", 64'(exp_wen), 64'(retire_wen_o));
                if (exp_wen) begin
                    check_field("retire_data_o", exp_data, retire_data_o);
                end
            end
            ret_idx++;
        end
    end

    // watchdog
    initial begin
        while (cycles <= limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, core still running after %0d cycles", cycles);
        $display("Test failed");
        $finish;
    end

    task automatic put(input logic [ilen-1:0] inst);
        prog[prog_len] = inst;
        prog_len++;
    endtask

    task automatic put_halt(input logic [ilen-1:0] inst);
        stop_idx = prog_len;
        put(inst);
    endtask

    task automatic run_test(input string name, input logic want_illegal);
        int err_start;
        err_start = errors;
        limit     = limit + 4 * prog_len;
        @(posedge clk);
        #1 reset_i = 1'b1;
        ret_idx = 0;
        for (int i = 0; i < reg_count; i++) begin
            mregs[i] = '0;
        end
        repeat (2) @(posedge clk);
        #1 reset_i = 1'b0;
        while (!halt_o) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);                       // nothing may retire now
        if (ret_idx != stop_idx + 1) begin
            $display("%0d retirements seen, %0d expected", ret_idx, stop_idx + 1);
            errors++;
        end
        check_field("halt_o", 64'(1), 64'(halt_o));
        check_field("illegal_o", 64'(want_illegal), 64'(illegal_o));
        check_field("pc_o", 64'((stop_idx + 1) * 4), pc_o);    // pc frozen after the halt
        if (errors == err_start) begin
            $display("%s: pass", name);
            n_pass++;
        end else begin
            $display("%s: fail", name);
            n_fail++;
        end
    endtask

    initial begin
        clk     = 1'b0;
        reset_i = 1'b1;
        void'($urandom(32'hd134));

        prog_len = 0;                                     // independent registers
        for (int r = 1; r < 16; r++) begin
            put((r % 2) ? enc_i(12'($urandom), 0, 3'b000, r) : enc_u(op_lui, 20'($urandom), r));
        end
        repeat (3) put(nop_inst);
        for (int i = 0; i < 38; i++) begin
            put(rand_op(16 + i % 16, 1 + $urandom % 15, 1 + $urandom % 15));
        end
        put_halt(inst_ebreak);
        run_test("random_alu", 1'b0);

        prog_len = 0;                                     // sources 1 to 3 back
        for (int r = 1; r <= 8; r++) begin
            put(enc_i(12'($urandom), 0, 3'b000, r));
        end
        for (int i = 3; i < 33; i++) begin
            put(rand_op(1 + i % 8, 1 + (i - 1 - i % 3) % 8, 1 + (i - 1 - (i + 1) % 3) % 8));
        end
        put_halt(inst_ebreak);
        run_test("dependencies", 1'b0);

        prog_len = 0;
        put(enc_i(12'd5, 0, 3'b000, 1));
        put(enc_r(7'h00, 1, 1, 3'b000, 0));               // add x0 still retires 10
        put(enc_r(7'h00, 1, 0, 3'b000, 2));
        put(enc_i(12'd7, 1, 3'b000, 0));
        put(nop_inst);
        put(enc_r(7'h00, 0, 0, 3'b110, 3));
        put(enc_r(7'h00, 1, 0, 3'b000, 4));
        put_halt(inst_ebreak);
        run_test("x0_writes", 1'b0);

        prog_len = 0;
        put(enc_u(op_lui, 20'h80000, 1));                 // sign extends to the top
        put(enc_u(op_auipc, 20'hfffff, 2));
        put(enc_i(12'hfff, 0, 3'b000, 3));
        put(enc_i(12'h03f, 3, 3'b101, 4));                // srli by 63
        put(enc_i(12'h43f, 3, 3'b101, 5));                // srai by 63
        put(enc_i(12'h03f, 3, 3'b001, 6));
        put(enc_r(7'h00, 3, 3, 3'b001, 7));               // shift count from -1
        put(enc_r(7'h00, 0, 1, 3'b010, 8));
        put(enc_r(7'h00, 0, 1, 3'b011, 9));
        put(enc_i(12'hfff, 0, 3'b011, 10));
        put(enc_i(12'h000, 1, 3'b010, 11));
        put(enc_r(7'h20, 3, 1, 3'b101, 12));
        put(enc_i(12'd64, 0, 3'b000, 13));
        put(enc_r(7'h00, 13, 3, 3'b101, 14));             // 64 wraps to 0
        put(enc_i(12'h420, 1, 3'b101, 15));
        put(enc_u(op_auipc, 20'h00001, 16));
        put_halt(inst_ebreak);
        run_test("edge_values", 1'b0);

        prog_len = 0;
        for (int i = 0; i < 12; i++) begin
            put(rand_op(rand_reg(), rand_reg(), rand_reg()));
        end
        put_halt(inst_ebreak);
        for (int i = 0; i < 6; i++) begin
            put(rand_op(rand_reg(), rand_reg(), rand_reg()));
        end
        run_test("ebreak_halt", 1'b0);

        prog_len = 0;
        for (int i = 0; i < 5; i++) begin
            put(rand_op(rand_reg(), rand_reg(), rand_reg()));
        end
        put_halt(32'hffff_ffff);                          // opcode 1111111
        for (int i = 0; i < 5; i++) begin
            put(rand_op(rand_reg(), rand_reg(), rand_reg()));
        end
        run_test("illegal_opcode", 1'b1);

        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 n_pass + n_fail, n_pass, n_fail, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== verilog/core_pkg.sv ====
// rv64i core definitions
package core_pkg;

    localparam int xlen       = 64;                 // data and pc width
    localparam int ilen       = 32;                 // instruction width
    localparam int reg_addr_w = 5;
    localparam int reg_count  = 1 << reg_addr_w;

    // major opcodes handled by the decoder
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_system = 7'b1110011;

    localparam logic [ilen-1:0] inst_ebreak = 32'h0010_0073;  // only system inst accepted

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_sll, alu_srl, alu_sra,
        alu_slt, alu_sltu,
        alu_lui                                     // passes source 2
    } alu_op_e;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [ilen-1:0] inst;
    } if_id_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       imm;
        logic [xlen-1:0]       rs1_data;
        logic [xlen-1:0]       rs2_data;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rd;
        alu_op_e               alu_op;
        logic                  src1_pc;             // pc as source 1
        logic                  src2_imm;            // immediate as source 2
        logic                  reg_wen;
        logic                  ebreak;
        logic                  illegal;
    } id_ex_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       result;
        logic                  reg_wen;
        logic                  ebreak;
        logic                  illegal;
    } ex_wb_t;

endpackage

// ==== verilog/core_top.sv ====
// rv64i four stage core
`timescale 1ns/100ps
module core_top (
    input  logic                           clk,
    input  logic                           reset_i,
    output logic [core_pkg::xlen-1:0]      pc_o,
    input  logic [core_pkg::ilen-1:0]      inst_i,
    output logic                           retire_valid_o,
    output logic [core_pkg::xlen-1:0]      retire_pc_o,
    output logic [core_pkg::reg_addr_w-1:0] retire_rd_o,
    output logic [core_pkg::xlen-1:0]      retire_data_o,
    output logic                           retire_wen_o,
    output logic                           halt_o,
    output logic                           illegal_o
);
    import core_pkg::*;

    logic                  fetch_valid;
    logic                  halt_req;
    if_id_t                fetch_data;
    logic                  id_valid;
    if_id_t                id_data;
    logic [reg_addr_w-1:0] rs1_addr;
    logic [reg_addr_w-1:0] rs2_addr;
    logic [xlen-1:0]       rs1_data;
    logic [xlen-1:0]       rs2_data;
    id_ex_t                id_out;
    logic                  ex_valid;
    id_ex_t                ex_data;
    ex_wb_t                ex_out;
    logic                  wb_valid;
    ex_wb_t                wb_data;
    logic                  wb_halt;
    logic                  halt_q;
    logic                  illegal_q;

    if_stage u_if_stage (.clk(clk), .reset_i(reset_i), .halt_req_i(halt_req),
                         .pc_o(pc_o), .fetch_valid_o(fetch_valid));

    assign fetch_data = '{pc: pc_o, inst: inst_i};   // imem answers in the same cycle

    pipe_reg #(.payload_t(if_id_t)) u_if_id (.clk(clk), .reset_i(reset_i),
        .valid_i(fetch_valid), .data_i(fetch_data), .valid_o(id_valid), .data_o(id_data));

    id_stage u_id_stage (.valid_i(id_valid), .data_i(id_data), .rs1_addr_o(rs1_addr),
        .rs2_addr_o(rs2_addr), .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .data_o(id_out), .halt_req_o(halt_req));

    reg_file u_reg_file (.clk(clk), .reset_i(reset_i), .rs1_addr_i(rs1_addr),
        .rs2_addr_i(rs2_addr), .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
        .wen_i(retire_wen_o), .waddr_i(wb_data.rd), .wdata_i(wb_data.result));

    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (.clk(clk), .reset_i(reset_i),
        .valid_i(id_valid), .data_i(id_out), .valid_o(ex_valid), .data_o(ex_data));

    ex_stage u_ex_stage (.data_i(ex_data), .fwd_valid_i(wb_valid), .fwd_i(wb_data),
        .data_o(ex_out));

    pipe_reg #(.payload_t(ex_wb_t)) u_ex_wb (.clk(clk), .reset_i(reset_i),
        .valid_i(ex_valid), .data_i(ex_out), .valid_o(wb_valid), .data_o(wb_data));

    // writeback is the output of the last stage register
    assign retire_valid_o = wb_valid;
    assign retire_pc_o    = wb_data.pc;
    assign retire_rd_o    = wb_data.rd;
    assign retire_data_o  = wb_data.result;
    assign retire_wen_o   = wb_valid && wb_data.reg_wen;
    assign wb_halt        = wb_valid && (wb_data.ebreak || wb_data.illegal);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            halt_q    <= 1'b0;
            illegal_q <= 1'b0;
        end else begin
            halt_q    <= halt_q || wb_halt;
            illegal_q <= illegal_q || (wb_valid && wb_data.illegal);
        end
    end

    assign halt_o    = halt_q || wb_halt;                          // up in the retire cycle
    assign illegal_o = illegal_q || (wb_valid && wb_data.illegal);

endmodule

// ==== verilog/ex_stage.sv ====
// execute stage with forwarding and alu
`timescale 1ns/100ps
module ex_stage (
    input  core_pkg::id_ex_t data_i,
    input  logic             fwd_valid_i,
    input  core_pkg::ex_wb_t fwd_i,
    output core_pkg::ex_wb_t data_o
);
    import core_pkg::*;

    logic            fwd_ok;
    logic            fwd_rs1;
    logic            fwd_rs2;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic [5:0]      shamt;
    logic [xlen-1:0] result;

    // writeback entry can feed both sources
    assign fwd_ok  = fwd_valid_i && fwd_i.reg_wen && (fwd_i.rd != '0);
    assign fwd_rs1 = fwd_ok && (fwd_i.rd == data_i.rs1);
    assign fwd_rs2 = fwd_ok && (fwd_i.rd == data_i.rs2);

    assign rs1_val = fwd_rs1 ? fwd_i.result : data_i.rs1_data;
    assign rs2_val = fwd_rs2 ? fwd_i.result : data_i.rs2_data;

    assign src1  = data_i.src1_pc  ? data_i.pc  : rs1_val;   // auipc
    assign src2  = data_i.src2_imm ? data_i.imm : rs2_val;
    assign shamt = src2[5:0];

    always_comb begin
        case (data_i.alu_op)
            alu_add:  result = src1 + src2;
            alu_sub:  result = src1 - src2;
            alu_and:  result = src1 & src2;
            alu_or:   result = src1 | src2;
            alu_xor:  result = src1 ^ src2;
            alu_sll:  result = src1 << shamt;
            alu_srl:  result = src1 >> shamt;
            alu_sra:  result = $signed(src1) >>> shamt;
            alu_slt:  result = {{(xlen-1){1'b0}}, $signed(src1) < $signed(src2)};
            alu_sltu: result = {{(xlen-1){1'b0}}, src1 < src2};
            alu_lui:  result = src2;
            default:  result = '0;
        endcase
    end

    always_comb begin
        data_o.pc      = data_i.pc;
        data_o.rd      = data_i.rd;
        data_o.result  = result;
        data_o.reg_wen = data_i.reg_wen;
        data_o.ebreak  = data_i.ebreak;
        data_o.illegal = data_i.illegal;
    end

endmodule

// ==== verilog/id_stage.sv ====
// instruction decoder
`timescale 1ns/100ps
module id_stage (
    input  logic                           valid_i,
    input  core_pkg::if_id_t               data_i,
    output logic [core_pkg::reg_addr_w-1:0] rs1_addr_o,
    output logic [core_pkg::reg_addr_w-1:0] rs2_addr_o,
    input  logic [core_pkg::xlen-1:0]      rs1_data_i,
    input  logic [core_pkg::xlen-1:0]      rs2_data_i,
    output core_pkg::id_ex_t               data_o,
    output logic                           halt_req_o
);
    import core_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_u;
    logic            use_u;
    alu_op_e         alu_op;
    logic            src1_pc;
    logic            src2_imm;
    logic            reg_wen;
    logic            ebreak;
    logic            illegal;

    assign opcode     = data_i.inst[6:0];
    assign funct3     = data_i.inst[14:12];
    assign funct7     = data_i.inst[31:25];
    assign rs1_addr_o = data_i.inst[19:15];
    assign rs2_addr_o = data_i.inst[24:20];

    assign imm_i = {{(xlen-12){data_i.inst[31]}}, data_i.inst[31:20]};
    assign imm_u = {{(xlen-32){data_i.inst[31]}}, data_i.inst[31:12], 12'b0};
    assign use_u = (opcode == op_lui) || (opcode == op_auipc);

    always_comb begin
        alu_op   = alu_add;
        src1_pc  = 1'b0;
        src2_imm = 1'b0;
        reg_wen  = 1'b0;
        ebreak   = 1'b0;
        illegal  = 1'b0;
        case (opcode)
            op_reg: begin
                reg_wen = 1'b1;
                case (funct3)
                    3'b000:  alu_op = funct7[5] ? alu_sub : alu_add;
                    3'b001:  alu_op = alu_sll;
                    3'b010:  alu_op = alu_slt;
                    3'b011:  alu_op = alu_sltu;
                    3'b100:  alu_op = alu_xor;
                    3'b101:  alu_op = funct7[5] ? alu_sra : alu_srl;
                    3'b110:  alu_op = alu_or;
                    default: alu_op = alu_and;
                endcase
                // funct7 is zero, or 0100000 for sub and sra
                illegal = ((funct7 & 7'b1011111) != 7'b0) ||
                          (funct7[5] && funct3 != 3'b000 && funct3 != 3'b101);
            end
            op_imm: begin
                reg_wen  = 1'b1;
                src2_imm = 1'b1;
                case (funct3)
                    3'b000:  alu_op = alu_add;
                    3'b001: begin
                        alu_op  = alu_sll;
                        illegal = funct7[6:1] != 6'b0;      // 6-bit shamt
                    end
                    3'b010:  alu_op = alu_slt;
                    3'b011:  alu_op = alu_sltu;
                    3'b100:  alu_op = alu_xor;
                    3'b101: begin
                        alu_op  = data_i.inst[30] ? alu_sra : alu_srl;
                        illegal = (funct7[6:1] & 6'b101111) != 6'b0;
                    end
                    3'b110:  alu_op = alu_or;
                    default: alu_op = alu_and;
                endcase
            end
            op_lui: begin
                alu_op   = alu_lui;
                src2_imm = 1'b1;
                reg_wen  = 1'b1;
            end
            op_auipc: begin
                src1_pc  = 1'b1;
                src2_imm = 1'b1;
                reg_wen  = 1'b1;
            end
            op_system: begin
                ebreak  = data_i.inst == inst_ebreak;
                illegal = data_i.inst != inst_ebreak;      // ecall and csr not handled
            end
            default: illegal = 1'b1;
        endcase
    end

    always_comb begin
        data_o.pc       = data_i.pc;
        data_o.imm      = use_u ? imm_u : imm_i;
        data_o.rs1_data = rs1_data_i;
        data_o.rs2_data = rs2_data_i;
        data_o.rs1      = rs1_addr_o;
        data_o.rs2      = rs2_addr_o;
        data_o.rd       = data_i.inst[11:7];
        data_o.alu_op   = alu_op;
        data_o.src1_pc  = src1_pc;
        data_o.src2_imm = src2_imm;
        data_o.reg_wen  = reg_wen && !illegal;    // halting inst never writes
        data_o.ebreak   = ebreak;
        data_o.illegal  = illegal;
    end

    assign halt_req_o = valid_i && (ebreak || illegal);

endmodule

// ==== verilog/if_stage.sv ====
// fetch stage
`timescale 1ns/100ps
module if_stage (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     halt_req_i,
    output logic [core_pkg::xlen-1:0] pc_o,
    output logic                     fetch_valid_o
);
    import core_pkg::*;

    logic [xlen-1:0] pc_q;
    logic            halted_q;                      // sticky until reset

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q     <= '0;
            halted_q <= 1'b0;
        end else begin
            if (halt_req_i) begin
                halted_q <= 1'b1;
            end
            if (fetch_valid_o) begin
                pc_q <= pc_q + xlen'(4);            // freeze once halting
            end
        end
    end

    assign pc_o          = pc_q;
    assign fetch_valid_o = !halted_q && !halt_req_i;  // next fetch becomes a bubble

endmodule

// ==== verilog/pipe_reg.sv ====
// pipeline stage register
`timescale 1ns/100ps
module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // payload holds its value across bubbles
    always_ff @(posedge clk) begin
        if (valid_i) begin
            data_o <= data_i;
        end
    end

endmodule

// ==== verilog/reg_file.sv ====
// integer register file
`timescale 1ns/100ps
module reg_file (
    input  logic                           clk,
    input  logic                           reset_i,
    input  logic [core_pkg::reg_addr_w-1:0] rs1_addr_i,
    input  logic [core_pkg::reg_addr_w-1:0] rs2_addr_i,
    output logic [core_pkg::xlen-1:0]      rs1_data_o,
    output logic [core_pkg::xlen-1:0]      rs2_data_o,
    input  logic                           wen_i,
    input  logic [core_pkg::reg_addr_w-1:0] waddr_i,
    input  logic [core_pkg::xlen-1:0]      wdata_i
);
    import core_pkg::*;

    logic [xlen-1:0] regs [reg_count];
    logic            wr_live;                       // write that really lands

    assign wr_live = wen_i && (waddr_i != '0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // same-cycle write is seen by the reader
    assign rs1_data_o = (wr_live && rs1_addr_i == waddr_i) ? wdata_i : regs[rs1_addr_i];
    assign rs2_data_o = (wr_live && rs2_addr_i == waddr_i) ? wdata_i : regs[rs2_addr_i];

endmodule
